//--- design/mad_types_pkg.sv
/*
  Data widths and vector types for the multiply and divide datapath
*/

package mad_types_pkg;

  //==========================================================
  // Widths
  //==========================================================
  // One operand word, RV32
  localparam int WORD_W = 32;
  // Enough to index any bit of a word
  localparam int CNT_W  = 5;

  //==========================================================
  // Vector types
  //==========================================================
  // Operand or result word
  typedef logic [WORD_W-1:0]   word_t;
  // Full product, also partial remainder in the low half
  typedef logic [2*WORD_W-1:0] dword_t;
  // Iteration count or bit position
  typedef logic [CNT_W-1:0]    cnt_t;

endpackage

//--- design/mad_op_pkg.sv
/*
  Operation codes and controller state encoding
*/

package mad_op_pkg;

  localparam int OP_W = 3;
  localparam int ST_W = 2;

  // Same order as funct3 of the M extension
  typedef enum logic [OP_W-1:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } mad_op_e;

  // Split state machine
  typedef enum logic [ST_W-1:0] {
    ST_IDLE  = 2'd0,
    ST_PREP  = 2'd1,
    ST_SPLIT = 2'd2,
    ST_DONE  = 2'd3
  } mad_st_e;

endpackage

//--- design/mad_step_if.sv
/*
  Step control bundle shared by controller, counter, operand prep and datapath
*/

`timescale 1ns/1ps

interface mad_step_if
  import mad_types_pkg::*;
();

  // Prep cycle and iteration cycles, from the FSM
  logic load;
  logic step;
  // Iteration count and early finish, from operand prep
  cnt_t cnt_init;
  logic early;
  // Current bit position, zero on the final step
  cnt_t cnt;
  logic last;

  modport ctrl_mp (output load, output step, input early, input last);
  modport prep_mp (output cnt_init, output early);
  modport cnt_mp  (input load, input step, input cnt_init, output cnt, output last);
  modport dp_mp   (
    input load,
    input step,
    input early,
    input cnt_init,
    input cnt,
    input last
  );

endinterface

//--- design/mad_ctrl.sv
/*
  Split state machine: idle, prep, split and done, with busy and done decode
*/

`timescale 1ns/1ps

module mad_ctrl
  import mad_op_pkg::*;
(
  input  logic          mad_clk,
  input  logic          cpurst_b,
  input  logic          start,
  input  logic          cancel,
  mad_step_if.ctrl_mp   step_if,
  output logic          busy,
  output logic          done
);

  mad_st_e state;
  mad_st_e state_nxt;

  //==========================================================
  // State register
  //==========================================================
  // Cancel wins over any transition
  always_ff @(posedge mad_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= ST_IDLE;
    else if (cancel)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  //==========================================================
  // Next state
  //==========================================================
  always_comb
  begin
    state_nxt = state;
    case (state)
      // Start only honoured here
      ST_IDLE:
        if (start)
          state_nxt = ST_PREP;
      // Single cycle, early result skips the iteration
      ST_PREP:
        state_nxt = step_if.early ? ST_DONE : ST_SPLIT;
      // Leave on the zero count step
      ST_SPLIT:
        if (step_if.step && step_if.last)
          state_nxt = ST_DONE;
      ST_DONE:
        state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  // Decode from state
  assign step_if.load = (state == ST_PREP);
  assign step_if.step = (state == ST_SPLIT);
  assign busy         = (state != ST_IDLE);
  assign done         = (state == ST_DONE);

  //==========================================================
  // Checks
  //==========================================================
  // Done lasts one cycle, nothing is accepted during it
  a_done_to_idle: assert property (@(posedge mad_clk) disable iff (!cpurst_b)
    done |=> (state == ST_IDLE));

  a_load_step_excl: assert property (@(posedge mad_clk) disable iff (!cpurst_b)
    !(step_if.load && step_if.step));

endmodule

//--- design/mad_split_cnt.sv
/*
  Split counter, loaded from the find-first-one count and stepped down
*/

`timescale 1ns/1ps

module mad_split_cnt
  import mad_types_pkg::*;
(
  input  logic          mad_clk,
  input  logic          cpurst_b,
  mad_step_if.cnt_mp    step_if
);

  cnt_t cnt_q;

  // Load in prep, count down while splitting
  // holds at zero on the final step instead of wrapping
  always_ff @(posedge mad_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cnt_q <= '0;
    else if (step_if.load)
      cnt_q <= step_if.cnt_init;
    else if (step_if.step && !step_if.last)
      cnt_q <= cnt_q - cnt_t'(1);
  end

  assign step_if.cnt  = cnt_q;
  // Zero count marks the last iteration
  assign step_if.last = (cnt_q == '0);

  //==========================================================
  // Checks
  //==========================================================
  // FSM must leave split once the zero count is consumed
  a_no_step_past_zero: assert property (@(posedge mad_clk) disable iff (!cpurst_b)
    (step_if.step && step_if.last) |=> !step_if.step);

endmodule

//--- design/mad_oper_prep.sv
/*
  Operand capture, magnitudes and sign flags, find-first-one and early finish
*/

`timescale 1ns/1ps

module mad_oper_prep
  import mad_types_pkg::*;
  import mad_op_pkg::*;
(
  input  logic          mad_clk,
  input  logic          cpurst_b,
  input  logic          start,
  input  logic          busy,
  input  mad_op_e       op_in,
  input  word_t         rs1_in,
  input  word_t         rs2_in,
  mad_step_if.prep_mp   step_if,
  output mad_op_e       op,
  output word_t         rs1,
  output word_t         mag1,
  output word_t         mag2,
  output logic          neg_q,
  output logic          neg_r
);

  word_t rs2;
  logic  is_mul;
  logic  neg1;
  logic  neg2;
  logic  zero1;
  logic  zero2;
  cnt_t  ff1_1;
  cnt_t  ff1_2;

  // Highest set bit, zero for an all-zero word
  function automatic cnt_t find_first_one(input word_t v);
    cnt_t idx;
    idx = '0;
    for (int i = 0; i < WORD_W; i++)
    begin
      if (v[i])
        idx = cnt_t'(i);
    end
    return idx;
  endfunction

  //==========================================================
  // Operand capture
  //==========================================================
  always_ff @(posedge mad_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      op <= MUL;
    else if (start && !busy)
      op <= op_in;
  end

  always_ff @(posedge mad_clk)
  begin
    if (start && !busy)
    begin
      rs1 <= rs1_in;
      rs2 <= rs2_in;
    end
  end

  //==========================================================
  // Signs and magnitudes
  //==========================================================
  assign is_mul = op inside {MUL, MULH, MULHSU, MULHU};
  // Only signed operands contribute a sign
  assign neg1   = (op inside {MULH, MULHSU, DIV, REM}) && rs1[WORD_W-1];
  assign neg2   = (op inside {MULH, DIV, REM}) && rs2[WORD_W-1];
  assign mag1   = neg1 ? (~rs1 + word_t'(1)) : rs1;
  assign mag2   = neg2 ? (~rs2 + word_t'(1)) : rs2;
  assign zero1  = (rs1 == '0);
  assign zero2  = (rs2 == '0);

  // Product or quotient negate, zero results stay positive
  assign neg_q  = is_mul ? ((neg1 ^ neg2) && !zero1 && !zero2)
                         : ((neg1 ^ neg2) && !zero2);
  // Remainder follows the dividend
  assign neg_r  = !is_mul && neg1;

  //==========================================================
  // Iteration count and early finish
  //==========================================================
  assign ff1_1  = find_first_one(mag1);
  assign ff1_2  = find_first_one(mag2);

  // Divide: distance between leading ones, dividend is the larger here
  assign step_if.cnt_init = is_mul ? ff1_2 : (ff1_1 - ff1_2);
  assign step_if.early    = is_mul ? (zero1 || zero2)
                                   : (zero2 || (mag1 < mag2));

endmodule

//--- design/mad_iter_dp.sv
/*
  Shift-add multiply and shift-subtract divide on one adder
  Sign fix, early results and the result register
*/

`timescale 1ns/1ps

module mad_iter_dp
  import mad_types_pkg::*;
  import mad_op_pkg::*;
(
  input  logic          mad_clk,
  input  logic          cpurst_b,
  mad_step_if.dp_mp     step_if,
  input  mad_op_e       op,
  input  word_t         rs1,
  input  word_t         mag1,
  input  word_t         mag2,
  input  logic          neg_q,
  input  logic          neg_r,
  output word_t         result
);

  // Product accumulator, partial remainder in the low half on divide
  dword_t acc;
  word_t  dvs;
  word_t  quo;
  dword_t add_a;
  dword_t add_b;
  dword_t sum;
  logic   add_cin;
  logic   is_div;
  logic   is_rem;
  logic   fits;
  dword_t acc_nxt;
  word_t  quo_nxt;
  dword_t prod_fix;
  word_t  div_sel;
  logic   div_neg;
  word_t  div_fix;
  word_t  early_val;
  word_t  final_val;

  assign is_div = op inside {DIV, DIVU, REM, REMU};
  assign is_rem = op inside {REM, REMU};

  //==========================================================
  // Shared adder
  //==========================================================
  always_comb
  begin
    if (is_div)
    begin
      // Remainder minus shifted divisor
      add_a   = {{WORD_W{1'b0}}, acc[WORD_W-1:0]};
      add_b   = ~{{WORD_W{1'b0}}, dvs};
      add_cin = 1'b1;
    end
    else
    begin
      // Doubled accumulator plus mag1 when the multiplier bit is set
      add_a   = {acc[2*WORD_W-2:0], 1'b0};
      add_b   = mag2[step_if.cnt] ? {{WORD_W{1'b0}}, mag1} : '0;
      add_cin = 1'b0;
    end
  end

  assign sum  = add_a + add_b + {{(2*WORD_W-1){1'b0}}, add_cin};
  // No borrow out of the top bit
  assign fits = !sum[2*WORD_W-1];

  always_comb
  begin
    if (is_div)
    begin
      acc_nxt = fits ? {{WORD_W{1'b0}}, sum[WORD_W-1:0]} : acc;
      quo_nxt = {quo[WORD_W-2:0], fits};
    end
    else
    begin
      acc_nxt = sum;
      quo_nxt = quo;
    end
  end

  //==========================================================
  // Iteration registers
  //==========================================================
  always_ff @(posedge mad_clk)
  begin
    if (step_if.load)
    begin
      acc <= is_div ? {{WORD_W{1'b0}}, mag1} : '0;
      // Divisor aligned with the dividend's leading one
      dvs <= mag2 << step_if.cnt_init;
      quo <= '0;
    end
    else if (step_if.step)
    begin
      acc <= acc_nxt;
      dvs <= dvs >> 1;
      quo <= quo_nxt;
    end
  end

  //==========================================================
  // Sign fix and result select
  //==========================================================
  assign prod_fix = neg_q ? (~acc_nxt + dword_t'(1)) : acc_nxt;
  assign div_sel  = is_rem ? acc_nxt[WORD_W-1:0] : quo_nxt;
  assign div_neg  = is_rem ? neg_r : neg_q;
  assign div_fix  = div_neg ? (~div_sel + word_t'(1)) : div_sel;

  always_comb
  begin
    case (op)
      MUL:                 final_val = prod_fix[WORD_W-1:0];
      MULH, MULHSU, MULHU: final_val = prod_fix[2*WORD_W-1:WORD_W];
      default:             final_val = div_fix;
    endcase
  end

  // Early cases: zero product, or divide by zero / small dividend
  always_comb
  begin
    if (!is_div)
      early_val = '0;
    else if (is_rem)
      early_val = rs1;
    else if (mag2 == '0)
      early_val = '1;
    else
      early_val = '0;
  end

  // Written on entry to done, held until the next result
  always_ff @(posedge mad_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      result <= '0;
    else if (step_if.load && step_if.early)
      result <= early_val;
    else if (step_if.step && step_if.last)
      result <= final_val;
  end

  //==========================================================
  // Checks
  //==========================================================
  // Iteration state must come from a prep cycle
  a_step_after_load: assert property (@(posedge mad_clk) disable iff (!cpurst_b)
    $rose(step_if.step) |-> $past(step_if.load));

endmodule

//--- design/mad_top.sv
/*
  Multiply and divide unit top level
*/

`timescale 1ns/1ps

module mad_top
  import mad_types_pkg::*;
  import mad_op_pkg::*;
(
  input  logic     mad_clk,
  input  logic     cpurst_b,
  input  logic     start,
  input  mad_op_e  op,
  input  word_t    rs1,
  input  word_t    rs2,
  input  logic     cancel,
  output logic     busy,
  output logic     done,
  output word_t    result
);

  // Captured operation and operand info for the datapath
  mad_op_e op_r;
  word_t   rs1_r;
  word_t   mag1;
  word_t   mag2;
  logic    neg_q;
  logic    neg_r;

  mad_step_if step_if ();

  //==========================================================
  // Control
  //==========================================================
  mad_ctrl mad_ctrl_i (
    .mad_clk  (mad_clk),
    .cpurst_b (cpurst_b),
    .start    (start),
    .cancel   (cancel),
    .step_if  (step_if.ctrl_mp),
    .busy     (busy),
    .done     (done)
  );

  mad_split_cnt mad_split_cnt_i (
    .mad_clk  (mad_clk),
    .cpurst_b (cpurst_b),
    .step_if  (step_if.cnt_mp)
  );

  //==========================================================
  // Datapath
  //==========================================================
  mad_oper_prep mad_oper_prep_i (
    .mad_clk  (mad_clk),
    .cpurst_b (cpurst_b),
    .start    (start),
    .busy     (busy),
    .op_in    (op),
    .rs1_in   (rs1),
    .rs2_in   (rs2),
    .step_if  (step_if.prep_mp),
    .op       (op_r),
    .rs1      (rs1_r),
    .mag1     (mag1),
    .mag2     (mag2),
    .neg_q    (neg_q),
    .neg_r    (neg_r)
  );

  mad_iter_dp mad_iter_dp_i (
    .mad_clk  (mad_clk),
    .cpurst_b (cpurst_b),
    .step_if  (step_if.dp_mp),
    .op       (op_r),
    .rs1      (rs1_r),
    .mag1     (mag1),
    .mag2     (mag2),
    .neg_q    (neg_q),
    .neg_r    (neg_r),
    .result   (result)
  );

endmodule

//--- tb/tb_mad_ref.svh
/*
  Reference RV32M results and the xorshift generator for random operands
*/

`ifndef TB_MAD_REF_SVH
`define TB_MAD_REF_SVH

//==========================================================
// Reference model
//==========================================================
// Products in 64 bits, divide follows the RV32M zero and overflow rules
function automatic word_t expected_result(input mad_op_e kind, input word_t a, input word_t b);
  logic signed [63:0] x_s;
  logic signed [63:0] y_s;
  logic signed [63:0] y_u;
  logic signed [63:0] x_u;
  logic signed [63:0] p;
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic               ovf;
  word_t              res;
  // Sign and zero extended copies of both operands
  x_s = {{32{a[31]}}, a};
  y_s = {{32{b[31]}}, b};
  x_u = {32'h0, a};
  y_u = {32'h0, b};
  sa  = a;
  sb  = b;
  // Most negative word divided by minus one
  ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
  p   = '0;
  res = '0;
  case (kind)
    MUL:
    begin
      p   = x_u * y_u;
      res = p[31:0];
    end
    MULH:
    begin
      p   = x_s * y_s;
      res = p[63:32];
    end
    MULHSU:
    begin
      p   = x_s * y_u;
      res = p[63:32];
    end
    MULHU:
    begin
      p   = x_u * y_u;
      res = p[63:32];
    end
    DIV:
    begin
      if (b == '0)
        res = 32'hFFFF_FFFF;
      else if (ovf)
        res = a;
      else
        res = sa / sb;
    end
    DIVU:    res = (b == '0) ? 32'hFFFF_FFFF : a / b;
    REM:
    begin
      if (b == '0)
        res = a;
      else if (ovf)
        res = 32'h0;
      else
        res = sa % sb;
    end
    REMU:    res = (b == '0) ? a : a % b;
    default: res = '0;
  endcase
  return res;
endfunction

// xorshift32 step, 13 17 5
function automatic word_t xorshift(input word_t s);
  word_t x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

`endif

//--- tb/tb_mad.sv
/*
  Testbench for the multiply and divide unit: clock, reset, stimulus, checks
*/

`timescale 1ns/1ps

module tb_mad
  import mad_types_pkg::*;
  import mad_op_pkg::*;
();

  logic    mad_clk;
  logic    cpurst_b;
  logic    start;
  mad_op_e op;
  word_t   rs1;
  word_t   rs2;
  logic    cancel;
  logic    busy;
  logic    done;
  word_t   result;

  // Expected result and latency per accepted start, -1 latency for a cancel
  word_t   exp_q[$];
  int      lat_q[$];
  int      pending;
  word_t   rng;
  word_t   corners [5];

  `include "tb_mad_ref.svh"

  mad_top mad_top_i (
    .mad_clk  (mad_clk),
    .cpurst_b (cpurst_b),
    .start    (start),
    .op       (op),
    .rs1      (rs1),
    .rs2      (rs2),
    .cancel   (cancel),
    .busy     (busy),
    .done     (done),
    .result   (result)
  );

  // 40 ns period
  initial
  begin
    mad_clk = 1'b0;
    forever #20 mad_clk = ~mad_clk;
  end

  //==========================================================
  // Helpers
  //==========================================================
  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic word_t rand_word();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Inputs move 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge mad_clk);
    #2;
  endtask

  // One start strobe, expected values queued first
  task automatic issue_op(input mad_op_e kind, input word_t a, input word_t b, input int lat);
    exp_q.push_back(expected_result(kind, a, b));
    lat_q.push_back(lat);
    pending++;
    op    = kind;
    rs1   = a;
    rs2   = b;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (pending != 0)
    begin
      next_cycle();
      n++;
      if (n > 50)
      begin
        $display("timeout waiting for the checker to close an operation");
        stop_on_error();
      end
    end
  endtask

  //==========================================================
  // Checking process
  //==========================================================
  // Falling edge, clear of clock and input changes
  initial
  begin : check_proc
    word_t exp_val;
    int    exp_lat;
    int    cycles;
    forever
    begin
      @(negedge mad_clk);
      if (cpurst_b && start && !busy)
      begin
        if (exp_q.size() == 0)
        begin
          $display("start accepted with no expected result queued");
          stop_on_error();
        end
        exp_val = exp_q.pop_front();
        exp_lat = lat_q.pop_front();
        cycles  = 0;
        if (exp_lat < 0)
        begin
          // Cancelled: busy drops and no done on the way
          do
          begin
            @(negedge mad_clk);
            cycles++;
            if (done)
            begin
              $display("done pulse seen after a cancelled operation");
              stop_on_error();
            end
            if (cycles > 40)
            begin
              $display("timeout waiting for busy to drop after cancel");
              stop_on_error();
            end
          end
          while (busy);
        end
        else
        begin
          do
          begin
            @(negedge mad_clk);
            cycles++;
            if (cycles > 40)
            begin
              $display("timeout waiting for done, none within 40 cycles of start");
              stop_on_error();
            end
          end
          while (!done);
          check_word("result", result, exp_val);
          check_bit("busy", busy, 1'b1);
          if (exp_lat > 0 && cycles != exp_lat)
          begin
            $display("done came %0d cycles after start, expected %0d", cycles, exp_lat);
            stop_on_error();
          end
        end
        pending--;
      end
    end
  end

  //==========================================================
  // Stimulus
  //==========================================================
  initial
  begin : stim_proc
    word_t a;
    word_t b;
    word_t sh;
    cpurst_b = 1'b0;
    start    = 1'b0;
    cancel   = 1'b0;
    op       = MUL;
    rs1      = '0;
    rs2      = '0;
    pending  = 0;
    rng      = 32'd14;
    corners  = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
    repeat (5) @(posedge mad_clk);
    #2;
    cpurst_b = 1'b1;
    next_cycle();

    // Quiet after reset
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    check_word("result", result, '0);

    // Every op on every pair of corner values
    for (int k = 0; k < 8; k++)
      for (int i = 0; i < 5; i++)
        for (int j = 0; j < 5; j++)
        begin
          issue_op(mad_op_e'(k[2:0]), corners[i], corners[j], 0);
          wait_idle();
        end

    // Random operands, divisor shifted down for longer quotients
    for (int n = 0; n < 160; n++)
    begin
      a  = rand_word();
      sh = rand_word();
      b  = rand_word() >> sh[4:0];
      issue_op(mad_op_e'(n[2:0]), a, b, 0);
      wait_idle();
    end

    // Early finish, done two cycles after start
    for (int k = 4; k < 8; k++)
    begin
      issue_op(mad_op_e'(k[2:0]), rand_word(), 32'h0, 2);
      wait_idle();
    end
    issue_op(DIV, 32'h5, 32'h9, 2);
    wait_idle();
    issue_op(REM, 32'hFFFF_FFFD, 32'd100, 2);
    wait_idle();
    issue_op(DIVU, 32'h7, 32'h8000_0000, 2);
    wait_idle();
    issue_op(REMU, 32'h10, 32'h11, 2);
    wait_idle();
    issue_op(MULH, 32'h0, rand_word(), 2);
    wait_idle();

    // Start while busy is dropped
    issue_op(MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
    repeat (3) next_cycle();
    check_bit("busy", busy, 1'b1);
    op    = DIVU;
    rs1   = 32'h55;
    rs2   = 32'h3;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    wait_idle();

    // Cancel mid split, then a normal op
    issue_op(MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, -1);
    repeat (5) next_cycle();
    cancel = 1'b1;
    next_cycle();
    cancel = 1'b0;
    wait_idle();
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    issue_op(DIV, 32'hFFFF_FF9C, 32'h7, 0);
    wait_idle();

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+tb
design/mad_types_pkg.sv
design/mad_op_pkg.sv
design/mad_step_if.sv
design/mad_ctrl.sv
design/mad_split_cnt.sv
design/mad_oper_prep.sv
design/mad_iter_dp.sv
design/mad_top.sv
tb/tb_mad.sv

//--- Makefile
# Verilator build and run of the multiply and divide unit testbench
TOP = tb_mad

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the run prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
